//--- include/priv_config.svh
`ifndef PRIV_CONFIG_SVH
`define PRIV_CONFIG_SVH

// datapath widths
`define XLEN           32
`define CSR_ADDR_W     12
`define CAUSE_W        5

// machine-level csr addresses
`define CSR_MSTATUS    12'h300
`define CSR_MISA       12'h301
`define CSR_MIE        12'h304
`define CSR_MTVEC      12'h305
`define CSR_MSCRATCH   12'h340
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MTVAL      12'h343
`define CSR_MIP        12'h344
`define CSR_MHARTID    12'hf14

// writable bits per register
`define MSTATUS_WMASK  32'h0000_0088
`define MIE_WMASK      32'h0000_0888
`define MIP_WMASK      32'h0000_0008
`define MEPC_WMASK     32'hffff_fffc
`define MCAUSE_WMASK   32'h8000_001f

// mstatus bit positions
`define MSTATUS_MIE    3
`define MSTATUS_MPIE   7

// rv32im with mxl = 1 on hart 0
`define MISA_VALUE     32'h4000_1100
`define HART_ID        32'h0000_0000
`define RESET_VECTOR   32'h0000_1000

// exception and interrupt codes
`define CAUSE_ILLEGAL  5'd2
`define CAUSE_ECALL_M  5'd11
`define IRQ_MSI        5'd3
`define IRQ_MTI        5'd7
`define IRQ_MEI        5'd11

`endif

//--- verilog/priv_pkg.sv
package priv_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // command port
   ////////////////////////////////////////////////////////////////////////////

   // operation requested by the caller on cmd_op
   typedef enum logic [2:0] {
      CMD_CSRRW     = 3'd0,
      CMD_CSRRS     = 3'd1,
      CMD_CSRRC     = 3'd2,
      CMD_ECALL     = 3'd3,
      CMD_EXCEPTION = 3'd4,
      CMD_MRET      = 3'd5
   } cmd_op_t;

   ////////////////////////////////////////////////////////////////////////////
   // controller to csr file
   ////////////////////////////////////////////////////////////////////////////

   // kind of csr access, none means no write this cycle
   typedef enum logic [1:0] {
      CSR_NONE  = 2'd0,
      CSR_WRITE = 2'd1,
      CSR_SET   = 2'd2,
      CSR_CLEAR = 2'd3
   } csr_op_t;

   // handshake fsm
   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_EXEC    = 2'd1,
      ST_RESPOND = 2'd2
   } ctrl_state_t;

endpackage

//--- verilog/csr_if.sv
`timescale 1ns/1ps
`include "priv_config.svh"

interface csr_if import priv_pkg::*; ();

   // csr access
   logic [`CSR_ADDR_W-1:0] addr;
   csr_op_t                op;
   logic [`XLEN-1:0]       wdata;
   logic [`XLEN-1:0]       rdata;
   logic                   addr_valid;

   // trap entry and return
   logic                   trap_take;
   logic                   trap_irq;
   logic [`CAUSE_W-1:0]    trap_code;
   logic [`XLEN-1:0]       trap_epc;
   logic [`XLEN-1:0]       trap_tval;
   logic                   mret_take;
   logic [`XLEN-1:0]       trap_pc;

   // highest enabled pending interrupt
   logic                   irq_pending;
   logic [`CAUSE_W-1:0]    irq_code;

   modport ctrl (
      output addr, op, wdata, trap_take, trap_irq, trap_code, trap_epc, trap_tval, mret_take,
      input  rdata, addr_valid, irq_pending, irq_code, trap_pc
   );

   modport csrs (
      input  addr, op, wdata, trap_take, trap_irq, trap_code, trap_epc, trap_tval, mret_take,
      output rdata, addr_valid, irq_pending, irq_code, trap_pc
   );

endinterface

//--- verilog/csr_file.sv
`timescale 1ns/1ps
`include "priv_config.svh"

module csr_file import priv_pkg::*; (
   input  logic clk,
   input  logic rstn,
   input  logic timer_intr,
   input  logic ext_intr,
   csr_if.csrs  bus
);

   logic [`XLEN-1:0] mstatus;
   logic [`XLEN-1:0] mie;
   logic [`XLEN-1:0] mip_sw;
   logic [`XLEN-1:0] mtvec;
   logic [`XLEN-1:0] mscratch;
   logic [`XLEN-1:0] mepc;
   logic [`XLEN-1:0] mcause;
   logic [`XLEN-1:0] mtval;

   logic [`XLEN-1:0] mip_rd;
   logic [`XLEN-1:0] wr_val;
   logic [`XLEN-1:0] pend;
   logic [`XLEN-1:0] tvec_base;

   function automatic logic [`XLEN-1:0] merge(input logic [`XLEN-1:0] old_val,
                                              input logic [`XLEN-1:0] new_val,
                                              input logic [`XLEN-1:0] mask);
      return (old_val & ~mask) | (new_val & mask);
   endfunction

   // software bit is stored, timer and external come straight from the pins
   assign mip_rd = mip_sw
                 | (`XLEN'(ext_intr) << `IRQ_MEI)
                 | (`XLEN'(timer_intr) << `IRQ_MTI);

   ////////////////////////////////////////////////////////////////////////////
   // read side
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      bus.addr_valid = 1'b1;
      case (bus.addr)
         `CSR_MSTATUS:  bus.rdata = mstatus;
         `CSR_MISA:     bus.rdata = `MISA_VALUE;
         `CSR_MIE:      bus.rdata = mie;
         `CSR_MTVEC:    bus.rdata = mtvec;
         `CSR_MSCRATCH: bus.rdata = mscratch;
         `CSR_MEPC:     bus.rdata = mepc;
         `CSR_MCAUSE:   bus.rdata = mcause;
         `CSR_MTVAL:    bus.rdata = mtval;
         `CSR_MIP:      bus.rdata = mip_rd;
         `CSR_MHARTID:  bus.rdata = `HART_ID;
         default: begin
            bus.rdata      = '0;
            bus.addr_valid = 1'b0;
         end
      endcase
   end

   // new value before the per-register mask
   always_comb begin
      case (bus.op)
         CSR_WRITE: wr_val = bus.wdata;
         CSR_SET:   wr_val = bus.rdata | bus.wdata;
         CSR_CLEAR: wr_val = bus.rdata & ~bus.wdata;
         default:   wr_val = bus.rdata;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // register updates
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         mstatus  <= '0;
         mie      <= '0;
         mip_sw   <= '0;
         mtvec    <= '0;
         mscratch <= '0;
         mepc     <= '0;
         mcause   <= '0;
         mtval    <= '0;
      end else if (bus.trap_take) begin
         mepc                   <= bus.trap_epc;
         mcause                 <= {bus.trap_irq, {(`XLEN-1-`CAUSE_W){1'b0}}, bus.trap_code};
         mtval                  <= bus.trap_tval;
         mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
         mstatus[`MSTATUS_MIE]  <= 1'b0;
      end else if (bus.mret_take) begin
         mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];
         mstatus[`MSTATUS_MPIE] <= 1'b1;
      end else if (bus.op != CSR_NONE) begin
         case (bus.addr)
            `CSR_MSTATUS:  mstatus  <= merge(mstatus, wr_val, `MSTATUS_WMASK);
            `CSR_MIE:      mie      <= merge(mie, wr_val, `MIE_WMASK);
            `CSR_MIP:      mip_sw   <= merge(mip_sw, wr_val, `MIP_WMASK);
            `CSR_MSCRATCH: mscratch <= wr_val;
            `CSR_MEPC:     mepc     <= merge(mepc, wr_val, `MEPC_WMASK);
            `CSR_MCAUSE:   mcause   <= merge(mcause, wr_val, `MCAUSE_WMASK);
            `CSR_MTVAL:    mtval    <= wr_val;
            `CSR_MTVEC: begin
               // only direct and vectored modes exist
               if (wr_val[1:0] < 2'd2) begin
                  mtvec <= wr_val;
               end
            end
            // misa and mhartid are read-only
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // interrupt selection and trap target
   ////////////////////////////////////////////////////////////////////////////

   assign pend = mip_rd & mie & {`XLEN{mstatus[`MSTATUS_MIE]}};

   // fixed priority mei > msi > mti
   always_comb begin
      bus.irq_pending = 1'b1;
      if (pend[`IRQ_MEI]) begin
         bus.irq_code = `IRQ_MEI;
      end else if (pend[`IRQ_MSI]) begin
         bus.irq_code = `IRQ_MSI;
      end else if (pend[`IRQ_MTI]) begin
         bus.irq_code = `IRQ_MTI;
      end else begin
         bus.irq_code    = '0;
         bus.irq_pending = 1'b0;
      end
   end

   assign tvec_base = {mtvec[`XLEN-1:2], 2'b00};

   always_comb begin
      if (bus.mret_take) begin
         bus.trap_pc = mepc;
      end else if (bus.trap_irq && mtvec[0]) begin
         // vectored mode, one word per cause
         bus.trap_pc = tvec_base + ({{(`XLEN-`CAUSE_W){1'b0}}, bus.trap_code} << 2);
      end else begin
         bus.trap_pc = tvec_base;
      end
   end

   // the controller never mixes trap entry with a csr access
   a_trap_no_write: assert property (@(posedge clk) disable iff (rstn)
      bus.trap_take |-> bus.op == CSR_NONE);

endmodule

//--- verilog/trap_ctrl.sv
`timescale 1ns/1ps
`include "priv_config.svh"

module trap_ctrl import priv_pkg::*; (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   cmd_req,
   input  cmd_op_t                cmd_op,
   input  logic [`CSR_ADDR_W-1:0] cmd_addr,
   input  logic [`XLEN-1:0]       cmd_wdata,
   input  logic [`XLEN-1:0]       cmd_pc,
   input  logic [`CAUSE_W-1:0]    cmd_cause,
   input  logic [`XLEN-1:0]       cmd_tval,
   output logic                   cmd_ack,
   output logic [`XLEN-1:0]       rsp_rdata,
   output logic                   rsp_redirect,
   output logic [`XLEN-1:0]       rsp_pc,
   csr_if.ctrl                    bus
);

   ctrl_state_t state;

   // captured command
   cmd_op_t                op_q;
   logic [`CSR_ADDR_W-1:0] addr_q;
   logic [`XLEN-1:0]       wdata_q;
   logic [`XLEN-1:0]       pc_q;
   logic [`CAUSE_W-1:0]    cause_q;
   logic [`XLEN-1:0]       tval_q;
   logic                   irq_q;
   logic [`CAUSE_W-1:0]    irq_code_q;

   logic exec;
   logic is_csr_cmd;
   logic act_irq;
   logic act_illegal;
   logic act_csr;
   logic act_ecall;
   logic act_exc;
   logic act_mret;

   ////////////////////////////////////////////////////////////////////////////
   // action select in exec
   ////////////////////////////////////////////////////////////////////////////

   assign exec       = (state == ST_EXEC);
   assign is_csr_cmd = (op_q == CMD_CSRRW) || (op_q == CMD_CSRRS) || (op_q == CMD_CSRRC);

   // a pending interrupt wins over whatever was issued
   assign act_irq   = exec && irq_q;
   assign act_csr   = exec && !irq_q && is_csr_cmd && bus.addr_valid;
   assign act_ecall = exec && !irq_q && (op_q == CMD_ECALL);
   assign act_exc   = exec && !irq_q && (op_q == CMD_EXCEPTION);
   assign act_mret  = exec && !irq_q && (op_q == CMD_MRET);

   // bad csr address or unknown op code
   assign act_illegal = exec && !irq_q && !act_csr && !act_ecall && !act_exc && !act_mret;

   assign bus.addr  = addr_q;
   assign bus.wdata = wdata_q;

   always_comb begin
      bus.op = CSR_NONE;
      if (act_csr) begin
         case (op_q)
            CMD_CSRRS: bus.op = CSR_SET;
            CMD_CSRRC: bus.op = CSR_CLEAR;
            default:   bus.op = CSR_WRITE;
         endcase
      end
   end

   assign bus.trap_take = act_irq || act_illegal || act_ecall || act_exc;
   assign bus.trap_irq  = act_irq;
   assign bus.trap_epc  = pc_q;
   assign bus.mret_take = act_mret;

   always_comb begin
      if (act_irq) begin
         bus.trap_code = irq_code_q;
      end else if (act_ecall) begin
         bus.trap_code = `CAUSE_ECALL_M;
      end else if (act_exc) begin
         bus.trap_code = cause_q;
      end else begin
         bus.trap_code = `CAUSE_ILLEGAL;
      end
   end

   assign bus.trap_tval = (act_irq || act_ecall) ? '0 : tval_q;

   ////////////////////////////////////////////////////////////////////////////
   // handshake fsm
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         state        <= ST_IDLE;
         cmd_ack      <= 1'b0;
         rsp_redirect <= 1'b0;
         rsp_pc       <= `RESET_VECTOR;
      end else begin
         case (state)
            ST_IDLE: begin
               if (cmd_req) begin
                  state <= ST_EXEC;
               end
            end
            ST_EXEC: begin
               state        <= ST_RESPOND;
               cmd_ack      <= 1'b1;
               rsp_redirect <= bus.trap_take || bus.mret_take;
               // without a redirect the caller moves to the next instruction
               rsp_pc       <= (bus.trap_take || bus.mret_take) ? bus.trap_pc : pc_q + `XLEN'(4);
            end
            ST_RESPOND: begin
               if (!cmd_req) begin
                  state   <= ST_IDLE;
                  cmd_ack <= 1'b0;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // interrupts are sampled only when a command is accepted
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && cmd_req) begin
         op_q       <= cmd_op;
         addr_q     <= cmd_addr;
         wdata_q    <= cmd_wdata;
         pc_q       <= cmd_pc;
         cause_q    <= cmd_cause;
         tval_q     <= cmd_tval;
         irq_q      <= bus.irq_pending;
         irq_code_q <= bus.irq_code;
      end
      if (exec) begin
         rsp_rdata <= act_csr ? bus.rdata : '0;
      end
   end

   // ack only answers a request still held at the exec edge
   a_ack_needs_req: assert property (@(posedge clk) disable iff (rstn)
      $rose(cmd_ack) |-> $past(cmd_req));

   a_trap_or_mret: assert property (@(posedge clk) disable iff (rstn)
      !(bus.trap_take && bus.mret_take));

endmodule

//--- verilog/priv_unit.sv
`timescale 1ns/1ps
`include "priv_config.svh"

module priv_unit import priv_pkg::*; (
   input  logic                   clk,
   input  logic                   rstn,
   // command port
   input  logic                   cmd_req,
   input  cmd_op_t                cmd_op,
   input  logic [`CSR_ADDR_W-1:0] cmd_addr,
   input  logic [`XLEN-1:0]       cmd_wdata,
   input  logic [`XLEN-1:0]       cmd_pc,
   input  logic [`CAUSE_W-1:0]    cmd_cause,
   input  logic [`XLEN-1:0]       cmd_tval,
   output logic                   cmd_ack,
   output logic [`XLEN-1:0]       rsp_rdata,
   output logic                   rsp_redirect,
   output logic [`XLEN-1:0]       rsp_pc,
   // interrupt lines, level sensitive
   input  logic                   timer_intr,
   input  logic                   ext_intr
);

   csr_if bus ();

   trap_ctrl u_trap_ctrl (
      .clk          (clk),
      .rstn         (rstn),
      .cmd_req      (cmd_req),
      .cmd_op       (cmd_op),
      .cmd_addr     (cmd_addr),
      .cmd_wdata    (cmd_wdata),
      .cmd_pc       (cmd_pc),
      .cmd_cause    (cmd_cause),
      .cmd_tval     (cmd_tval),
      .cmd_ack      (cmd_ack),
      .rsp_rdata    (rsp_rdata),
      .rsp_redirect (rsp_redirect),
      .rsp_pc       (rsp_pc),
      .bus          (bus.ctrl)
   );

   csr_file u_csr_file (
      .clk        (clk),
      .rstn       (rstn),
      .timer_intr (timer_intr),
      .ext_intr   (ext_intr),
      .bus        (bus.csrs)
   );

endmodule

//--- verif/priv_unit_tb.sv
`timescale 1ns/1ps
`include "priv_config.svh"

module priv_unit_tb import priv_pkg::*; ();

   localparam int CLK_PERIOD  = 100;
   localparam int DRIVE_DLY   = 2;
   localparam int TIMEOUT     = 40;
   localparam int ACK_LATENCY = 2;
   localparam int NUM_COLS    = 11;
   localparam int MAX_TESTS   = 64;
   localparam int NUM_RAND    = 4;

   logic                   clk;
   logic                   rstn;
   logic                   cmd_req;
   cmd_op_t                cmd_op;
   logic [`CSR_ADDR_W-1:0] cmd_addr;
   logic [`XLEN-1:0]       cmd_wdata;
   logic [`XLEN-1:0]       cmd_pc;
   logic [`CAUSE_W-1:0]    cmd_cause;
   logic [`XLEN-1:0]       cmd_tval;
   logic                   cmd_ack;
   logic [`XLEN-1:0]       rsp_rdata;
   logic                   rsp_redirect;
   logic [`XLEN-1:0]       rsp_pc;
   logic                   timer_intr;
   logic                   ext_intr;

   // one row of NUM_COLS words per test
   logic [31:0] vec [0:NUM_COLS*MAX_TESTS-1];
   integer      seed;
   int          n_tests;
   int          n_fail;
   logic        timed_out;

   priv_unit dut (.*);

   always #(CLK_PERIOD/2) clk = ~clk;

   function automatic string op_name(input logic [2:0] op);
      case (op)
         3'd0:    return "csrrw";
         3'd1:    return "csrrs";
         3'd2:    return "csrrc";
         3'd3:    return "ecall";
         3'd4:    return "exception";
         3'd5:    return "mret";
         default: return "unknown";
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // four-phase command driver with response checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic issue_cmd(input logic [2:0] op, input logic [`CSR_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, input logic [31:0] pc,
                            input logic [`CAUSE_W-1:0] cause, input logic [31:0] tval,
                            input logic timer, input logic ext, input logic [31:0] exp_rdata,
                            input logic exp_redirect, input logic [31:0] exp_pc);
      int wait_cnt;
      int errs;
      errs = 0;
      @(posedge clk);
      #DRIVE_DLY;
      cmd_op     = cmd_op_t'(op);
      cmd_addr   = addr;
      cmd_wdata  = wdata;
      cmd_pc     = pc;
      cmd_cause  = cause;
      cmd_tval   = tval;
      timer_intr = timer;
      ext_intr   = ext;
      cmd_req    = 1'b1;
      wait_cnt   = 0;
      while (!cmd_ack && wait_cnt < TIMEOUT) begin
         @(posedge clk);
         #DRIVE_DLY;
         wait_cnt++;
      end
      if (!cmd_ack) begin
         $display("test %0d: the DUT did not acknowledge the command in time", n_tests);
         timed_out = 1'b1;
         errs++;
      end else begin
         assert (wait_cnt == ACK_LATENCY) else begin
            $display("test %0d: acknowledge came after %0d cycles instead of %0d",
                     n_tests, wait_cnt, ACK_LATENCY);
            errs++;
         end
         assert (rsp_rdata === exp_rdata) else begin
            $display("Error: rsp_rdata expected 0x%08h, got 0x%08h", exp_rdata, rsp_rdata);
            errs++;
         end
         assert (rsp_redirect === exp_redirect) else begin
            $display("Error: rsp_redirect expected 0x%0h, got 0x%0h", exp_redirect,
                     rsp_redirect);
            errs++;
         end
         assert (rsp_pc === exp_pc) else begin
            $display("Error: rsp_pc expected 0x%08h, got 0x%08h", exp_pc, rsp_pc);
            errs++;
         end
      end
      // release phase
      cmd_req  = 1'b0;
      wait_cnt = 0;
      while (cmd_ack && wait_cnt < TIMEOUT) begin
         @(posedge clk);
         #DRIVE_DLY;
         wait_cnt++;
      end
      if (cmd_ack) begin
         $display("test %0d: acknowledge stayed high after the request was dropped", n_tests);
         timed_out = 1'b1;
         errs++;
      end
      if (errs == 0) begin
         $display("test %0d %s addr 0x%03h: passed", n_tests, op_name(op), addr);
      end else begin
         $display("test %0d %s addr 0x%03h: FAILED", n_tests, op_name(op), addr);
         n_fail++;
      end
      n_tests++;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int          i;
      int          base;
      int          n_file;
      logic [31:0] rnd;
      logic [31:0] prev;
      clk        = 1'b0;
      rstn       = 1'b1;
      cmd_req    = 1'b0;
      cmd_op     = CMD_CSRRW;
      cmd_addr   = '0;
      cmd_wdata  = '0;
      cmd_pc     = '0;
      cmd_cause  = '0;
      cmd_tval   = '0;
      timer_intr = 1'b0;
      ext_intr   = 1'b0;
      seed       = 32'h25a1db58;
      n_tests    = 0;
      n_fail     = 0;
      n_file     = 0;
      timed_out  = 1'b0;
      // all ones marks the end of the vectors
      for (i = 0; i < NUM_COLS*MAX_TESTS; i++) begin
         vec[i] = '1;
      end
      $readmemh("verif/priv_tests.txt", vec);

      repeat (10) @(posedge clk);
      #DRIVE_DLY;
      rstn = 1'b0;

      // mscratch is zero out of reset
      prev = '0;
      for (i = 0; i < NUM_RAND && !timed_out; i++) begin
         rnd = $random(seed);
         issue_cmd(3'd0, `CSR_MSCRATCH, rnd, 32'h40 + 8*i, '0, '0, 1'b0, 1'b0,
                   prev, 1'b0, 32'h44 + 8*i);
         issue_cmd(3'd1, `CSR_MSCRATCH, '0, 32'h44 + 8*i, '0, '0, 1'b0, 1'b0,
                   rnd, 1'b0, 32'h48 + 8*i);
         prev = rnd;
      end
      // back to zero before the vector file
      if (!timed_out) begin
         issue_cmd(3'd2, `CSR_MSCRATCH, '1, 32'h80, '0, '0, 1'b0, 1'b0, prev, 1'b0, 32'h84);
      end

      for (i = 0; i < MAX_TESTS && !timed_out; i++) begin
         base = i * NUM_COLS;
         if (vec[base] == 32'hffff_ffff) break;
         issue_cmd(vec[base][2:0], vec[base+1][`CSR_ADDR_W-1:0], vec[base+2], vec[base+3],
                   vec[base+4][`CAUSE_W-1:0], vec[base+5], vec[base+6][0], vec[base+7][0],
                   vec[base+8], vec[base+9][0], vec[base+10]);
         n_file++;
      end
      if (n_file == 0) begin
         $display("no test vectors were read from verif/priv_tests.txt");
         n_fail++;
      end

      $display("%0d tests run, %0d passed, %0d failed", n_tests, n_tests - n_fail, n_fail);
      if (n_fail == 0 && !timed_out) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- verif/priv_tests.txt
// op addr wdata pc cause tval timer ext, then expected rdata redirect pc
// op 0 csrrw, 1 csrrs, 2 csrrc, 3 ecall, 4 exception, 5 mret
// reset values and plain read/modify/write
1 300 00000000 00000100 00 00000000 0 0 00000000 0 00000104
1 305 00000000 00000104 00 00000000 0 0 00000000 0 00000108
1 341 00000000 00000108 00 00000000 0 0 00000000 0 0000010c
0 340 12345678 0000010c 00 00000000 0 0 00000000 0 00000110
1 340 0000f000 00000110 00 00000000 0 0 12345678 0 00000114
2 340 00000678 00000114 00 00000000 0 0 1234f678 0 00000118
1 340 00000000 00000118 00 00000000 0 0 1234f000 0 0000011c
// masked and read-only registers, mtvec mode 2 is dropped
0 300 ffffffff 0000011c 00 00000000 0 0 00000000 0 00000120
0 304 ffffffff 00000120 00 00000000 0 0 00000000 0 00000124
1 304 00000000 00000124 00 00000000 0 0 00000888 0 00000128
0 301 00000000 00000128 00 00000000 0 0 40001100 0 0000012c
1 301 00000000 0000012c 00 00000000 0 0 40001100 0 00000130
0 305 00000800 00000130 00 00000000 0 0 00000000 0 00000134
0 305 00000a02 00000134 00 00000000 0 0 00000800 0 00000138
// illegal csr address, then trap state and mret
0 7c0 00000000 00000138 00 deadbeef 0 0 00000000 1 00000800
1 342 00000000 0000013c 00 00000000 0 0 00000002 0 00000140
1 343 00000000 00000140 00 00000000 0 0 deadbeef 0 00000144
1 341 00000000 00000144 00 00000000 0 0 00000138 0 00000148
1 300 00000000 00000148 00 00000000 0 0 00000080 0 0000014c
5 000 00000000 0000014c 00 00000000 0 0 00000000 1 00000138
1 300 00000000 00000150 00 00000000 0 0 00000088 0 00000154
// ecall and a reported exception
3 000 00000000 00000154 00 00000000 0 0 00000000 1 00000800
1 342 00000000 00000158 00 00000000 0 0 0000000b 0 0000015c
4 000 00000000 0000015c 05 00001234 0 0 00000000 1 00000800
1 342 00000000 00000160 00 00000000 0 0 00000005 0 00000164
1 300 00000000 00000164 00 00000000 0 0 00000000 0 00000168
// interrupts, masked first, then direct and vectored mtvec
1 340 00000000 00000168 00 00000000 1 0 1234f000 0 0000016c
0 300 00000008 0000016c 00 00000000 0 0 00000000 0 00000170
1 340 00000000 00000170 00 00000000 1 0 00000000 1 00000800
0 305 00000801 00000174 00 00000000 0 0 00000800 0 00000178
0 300 00000008 00000178 00 00000000 0 0 00000080 0 0000017c
0 340 00000055 0000017c 00 00000000 1 1 00000000 1 0000082c
1 342 00000000 00000180 00 00000000 0 0 8000000b 0 00000184
1 340 00000000 00000184 00 00000000 0 0 1234f000 0 00000188
0 300 00000008 00000188 00 00000000 0 0 00000080 0 0000018c
1 340 00000000 0000018c 00 00000000 1 0 00000000 1 0000081c
1 342 00000000 00000190 00 00000000 0 0 80000007 0 00000194

//--- sim.f
+incdir+include
verilog/priv_pkg.sv
verilog/csr_if.sv
verilog/csr_file.sv
verilog/trap_ctrl.sv
verilog/priv_unit.sv
verif/priv_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the priv_unit testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module priv_unit_tb \
   && ./obj_dir/Vpriv_unit_tb > sim.log 2>&1 \
   || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
